//--- common/raster_pkg.sv
package raster_pkg;

    //////////////////////////////////////////////////
    // Widths and fixed-point formats
    //////////////////////////////////////////////////

    // Integer pixel coordinate on screen
    typedef logic [9:0] coord_t;

    // Signed fixed point, format set by the caller
    typedef logic signed [31:0] fixed_t;

    // One color channel and a packed RGB triple
    // Red in the top byte, blue in the bottom byte
    typedef logic [7:0] channel_t;
    typedef logic [23:0] rgb_t;

    // Edge function values carry 4 fractional bits
    localparam int PIXEL_FRAC_BITS = 4;

    // Barycentric weights and the area reciprocal carry 16
    localparam int PRECISION_FRAC_BITS = 16;

    //////////////////////////////////////////////////
    // Fixed-point helpers
    //////////////////////////////////////////////////

    // Integer to fixed point with frac fractional bits
    function automatic fixed_t to_fixed(input int value, input int frac);
        return fixed_t'(value <<< frac);
    endfunction

    // Product of two fixed values, scaled back by frac bits
    // Full 64-bit product so nothing overflows before the shift
    function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b, input int frac);
        logic signed [63:0] prod;
        prod = 64'(a) * 64'(b);
        return fixed_t'(prod >>> frac);
    endfunction

    // Limit value to the range lo..hi, both ends included
    function automatic fixed_t clamp_fixed(input fixed_t value, input fixed_t lo,
                                           input fixed_t hi);
        if (value < lo) begin
            return lo;
        end
        if (value > hi) begin
            return hi;
        end
        return value;
    endfunction

endpackage

//--- interpolator/edge_decode.sv
`timescale 1ns/1ps

module edge_decode (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               tri_valid,
    input  logic               pix_valid,
    input  raster_pkg::coord_t v0_x,
    input  raster_pkg::coord_t v0_y,
    input  raster_pkg::coord_t v1_x,
    input  raster_pkg::coord_t v1_y,
    input  raster_pkg::coord_t v2_x,
    input  raster_pkg::coord_t v2_y,
    input  raster_pkg::rgb_t   v0_color,
    input  raster_pkg::rgb_t   v1_color,
    input  raster_pkg::rgb_t   v2_color,
    input  raster_pkg::fixed_t area_inv,
    input  raster_pkg::coord_t pix_x,
    input  raster_pkg::coord_t pix_y,
    output logic               dec_valid,
    output raster_pkg::fixed_t f01,
    output raster_pkg::fixed_t f12,
    output raster_pkg::fixed_t f20,
    output raster_pkg::coord_t dec_v0_x,
    output raster_pkg::coord_t dec_v0_y,
    output raster_pkg::coord_t dec_v1_x,
    output raster_pkg::coord_t dec_v1_y,
    output raster_pkg::coord_t dec_v2_x,
    output raster_pkg::coord_t dec_v2_y,
    output raster_pkg::rgb_t   dec_v0_color,
    output raster_pkg::rgb_t   dec_v1_color,
    output raster_pkg::rgb_t   dec_v2_color,
    output raster_pkg::fixed_t dec_area_inv,
    output raster_pkg::coord_t dec_pix_x,
    output raster_pkg::coord_t dec_pix_y
);
    import raster_pkg::*;

    // Edge function from p0 to p1 at sample q, y axis points down
    // F = (y0 - y1) * qx + (x1 - x0) * qy + (x0 * y1 - y0 * x1)
    function automatic fixed_t edge_value(input coord_t x0, input coord_t y0,
                                          input coord_t x1, input coord_t y1,
                                          input coord_t qx, input coord_t qy);
        fixed_t fx0;
        fixed_t fy0;
        fixed_t fx1;
        fixed_t fy1;
        fixed_t fqx;
        fixed_t fqy;
        fx0 = to_fixed(int'(x0), PIXEL_FRAC_BITS);
        fy0 = to_fixed(int'(y0), PIXEL_FRAC_BITS);
        fx1 = to_fixed(int'(x1), PIXEL_FRAC_BITS);
        fy1 = to_fixed(int'(y1), PIXEL_FRAC_BITS);
        fqx = to_fixed(int'(qx), PIXEL_FRAC_BITS);
        fqy = to_fixed(int'(qy), PIXEL_FRAC_BITS);
        return fixed_mul(fy0 - fy1, fqx, PIXEL_FRAC_BITS)
             + fixed_mul(fx1 - fx0, fqy, PIXEL_FRAC_BITS)
             + fixed_mul(fx0, fy1, PIXEL_FRAC_BITS)
             - fixed_mul(fy0, fx1, PIXEL_FRAC_BITS);
    endfunction

    //////////////////////////////////////////////////
    // Stage 1, triangle and pixel latch
    //////////////////////////////////////////////////

    coord_t tri_v0_x, tri_v0_y, tri_v1_x, tri_v1_y, tri_v2_x, tri_v2_y;
    rgb_t   tri_v0_color, tri_v1_color, tri_v2_color;
    fixed_t tri_area_inv;
    coord_t lat_pix_x, lat_pix_y;
    logic   lat_valid;

    // One pixel enters per accepted pixel transfer
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lat_valid <= 1'b0;
        end else if (!stall) begin
            lat_valid <= pix_valid;
        end
    end

    // Triangle is kept until the next triangle transfer
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (tri_valid) begin
                tri_v0_x     <= v0_x;
                tri_v0_y     <= v0_y;
                tri_v1_x     <= v1_x;
                tri_v1_y     <= v1_y;
                tri_v2_x     <= v2_x;
                tri_v2_y     <= v2_y;
                tri_v0_color <= v0_color;
                tri_v1_color <= v1_color;
                tri_v2_color <= v2_color;
                tri_area_inv <= area_inv;
            end
            if (pix_valid) begin
                lat_pix_x <= pix_x;
                lat_pix_y <= pix_y;
            end
        end
    end

    // Edge values against the latched triangle
    fixed_t edge01, edge12, edge20;
    assign edge01 = edge_value(tri_v0_x, tri_v0_y, tri_v1_x, tri_v1_y, lat_pix_x, lat_pix_y);
    assign edge12 = edge_value(tri_v1_x, tri_v1_y, tri_v2_x, tri_v2_y, lat_pix_x, lat_pix_y);
    assign edge20 = edge_value(tri_v2_x, tri_v2_y, tri_v0_x, tri_v0_y, lat_pix_x, lat_pix_y);

    //////////////////////////////////////////////////
    // Stage 2, edge register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= lat_valid;
        end
    end

    // Triangle data rides along with its edge values
    always_ff @(posedge clk) begin
        if (!stall) begin
            f01          <= edge01;
            f12          <= edge12;
            f20          <= edge20;
            dec_v0_x     <= tri_v0_x;
            dec_v0_y     <= tri_v0_y;
            dec_v1_x     <= tri_v1_x;
            dec_v1_y     <= tri_v1_y;
            dec_v2_x     <= tri_v2_x;
            dec_v2_y     <= tri_v2_y;
            dec_v0_color <= tri_v0_color;
            dec_v1_color <= tri_v1_color;
            dec_v2_color <= tri_v2_color;
            dec_area_inv <= tri_area_inv;
            dec_pix_x    <= lat_pix_x;
            dec_pix_y    <= lat_pix_y;
        end
    end

endmodule

//--- interpolator/coverage_execute.sv
`timescale 1ns/1ps

module coverage_execute #(
    parameter int EDGE_TOLERANCE = 8
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               dec_valid,
    input  raster_pkg::fixed_t f01,
    input  raster_pkg::fixed_t f12,
    input  raster_pkg::fixed_t f20,
    input  raster_pkg::fixed_t area_inv,
    input  raster_pkg::coord_t v0_x,
    input  raster_pkg::coord_t v0_y,
    input  raster_pkg::coord_t v1_x,
    input  raster_pkg::coord_t v1_y,
    input  raster_pkg::coord_t v2_x,
    input  raster_pkg::coord_t v2_y,
    input  raster_pkg::rgb_t   v0_color,
    input  raster_pkg::rgb_t   v1_color,
    input  raster_pkg::rgb_t   v2_color,
    input  raster_pkg::coord_t pix_x,
    input  raster_pkg::coord_t pix_y,
    output logic               exe_valid,
    output logic               covered,
    output raster_pkg::fixed_t b0,
    output raster_pkg::fixed_t b1,
    output raster_pkg::fixed_t b2,
    output raster_pkg::rgb_t   exe_v0_color,
    output raster_pkg::rgb_t   exe_v1_color,
    output raster_pkg::rgb_t   exe_v2_color,
    output raster_pkg::coord_t exe_pix_x,
    output raster_pkg::coord_t exe_pix_y
);
    import raster_pkg::*;

    // Lowest edge value still counted as on the edge
    localparam fixed_t TOL_NEG = -fixed_t'(EDGE_TOLERANCE);

    // Weight of one in barycentric format
    localparam fixed_t WEIGHT_ONE = to_fixed(1, PRECISION_FRAC_BITS);

    // Top edge runs flat toward +x, left edge goes up the screen
    function automatic logic is_top_left(input coord_t x0, input coord_t y0,
                                         input coord_t x1, input coord_t y1);
        return ((y0 == y1) && (x1 > x0)) || (y0 > y1);
    endfunction

    // Inside one edge, or on it within tolerance when top-left
    function automatic logic edge_inside(input fixed_t f, input logic top_left);
        return (f > 0) || ((f >= TOL_NEG) && top_left);
    endfunction

    //////////////////////////////////////////////////
    // Coverage
    //////////////////////////////////////////////////

    logic top_left01, top_left12, top_left20;
    assign top_left01 = is_top_left(v0_x, v0_y, v1_x, v1_y);
    assign top_left12 = is_top_left(v1_x, v1_y, v2_x, v2_y);
    assign top_left20 = is_top_left(v2_x, v2_y, v0_x, v0_y);

    logic covered_c;
    assign covered_c = edge_inside(f01, top_left01)
                     && edge_inside(f12, top_left12)
                     && edge_inside(f20, top_left20);

    //////////////////////////////////////////////////
    // Barycentric weights
    //////////////////////////////////////////////////

    // Weight of a vertex comes from the edge opposite it
    // edge in 4 frac bits times reciprocal in 16, back to 16
    fixed_t b0_raw, b1_raw, b2_raw;
    assign b0_raw = fixed_mul(f12, area_inv, PIXEL_FRAC_BITS);
    assign b1_raw = fixed_mul(f20, area_inv, PIXEL_FRAC_BITS);
    assign b2_raw = fixed_mul(f01, area_inv, PIXEL_FRAC_BITS);

    // Outside pixels give weights past 0..1, clip them
    fixed_t b0_c, b1_c, b2_c;
    assign b0_c = clamp_fixed(b0_raw, '0, WEIGHT_ONE);
    assign b1_c = clamp_fixed(b1_raw, '0, WEIGHT_ONE);
    assign b2_c = clamp_fixed(b2_raw, '0, WEIGHT_ONE);

    // Stage register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exe_valid <= 1'b0;
        end else if (!stall) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            covered      <= covered_c;
            b0           <= b0_c;
            b1           <= b1_c;
            b2           <= b2_c;
            exe_v0_color <= v0_color;
            exe_v1_color <= v1_color;
            exe_v2_color <= v2_color;
            exe_pix_x    <= pix_x;
            exe_pix_y    <= pix_y;
        end
    end

endmodule

//--- interpolator/shade_result.sv
`timescale 1ns/1ps

module shade_result (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               exe_valid,
    input  logic               covered,
    input  raster_pkg::fixed_t b0,
    input  raster_pkg::fixed_t b1,
    input  raster_pkg::fixed_t b2,
    input  raster_pkg::rgb_t   v0_color,
    input  raster_pkg::rgb_t   v1_color,
    input  raster_pkg::rgb_t   v2_color,
    input  raster_pkg::coord_t pix_x,
    input  raster_pkg::coord_t pix_y,
    output logic               out_valid,
    output raster_pkg::coord_t out_x,
    output raster_pkg::coord_t out_y,
    output logic               out_covered,
    output raster_pkg::rgb_t   out_color
);
    import raster_pkg::*;

    // Number of color channels in rgb_t
    localparam int CHANNELS = 3;

    // Weighted channel value, truncated, then held inside vertex range
    function automatic channel_t shade_channel(input fixed_t w0, input channel_t c0,
                                               input fixed_t w1, input channel_t c1,
                                               input fixed_t w2, input channel_t c2);
        fixed_t   sum;
        fixed_t   whole;
        channel_t c_min;
        channel_t c_max;
        sum = fixed_mul(w0, to_fixed(int'(c0), PRECISION_FRAC_BITS), PRECISION_FRAC_BITS)
            + fixed_mul(w1, to_fixed(int'(c1), PRECISION_FRAC_BITS), PRECISION_FRAC_BITS)
            + fixed_mul(w2, to_fixed(int'(c2), PRECISION_FRAC_BITS), PRECISION_FRAC_BITS);
        // Drop the fraction
        whole = sum >>> PRECISION_FRAC_BITS;
        c_min = (c0 < c1) ? c0 : c1;
        c_min = (c_min < c2) ? c_min : c2;
        c_max = (c0 > c1) ? c0 : c1;
        c_max = (c_max > c2) ? c_max : c2;
        // Rounding loss can push a flat color off by one, the range fixes that
        whole = clamp_fixed(whole, fixed_t'(c_min), fixed_t'(c_max));
        return channel_t'(whole);
    endfunction

    //////////////////////////////////////////////////
    // Color interpolation
    //////////////////////////////////////////////////

    rgb_t shade_color;

    // Channel 0 is blue in the low byte, channel 2 red in the high byte
    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel
        assign shade_color[ch*8 +: 8] = shade_channel(b0, v0_color[ch*8 +: 8],
                                                      b1, v1_color[ch*8 +: 8],
                                                      b2, v2_color[ch*8 +: 8]);
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= exe_valid;
        end
    end

    // Held while the sink is not ready
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_x       <= pix_x;
            out_y       <= pix_y;
            out_covered <= covered;
            out_color   <= shade_color;
        end
    end

endmodule

//--- logic/triangle_interpolator.sv
`timescale 1ns/1ps

module triangle_interpolator #(
    parameter int EDGE_TOLERANCE = 8
) (
    input  logic               clk,
    input  logic               rstn,
    // Triangle stream
    input  logic               tri_valid,
    output logic               tri_ready,
    input  raster_pkg::coord_t v0_x,
    input  raster_pkg::coord_t v0_y,
    input  raster_pkg::rgb_t   v0_color,
    input  raster_pkg::coord_t v1_x,
    input  raster_pkg::coord_t v1_y,
    input  raster_pkg::rgb_t   v1_color,
    input  raster_pkg::coord_t v2_x,
    input  raster_pkg::coord_t v2_y,
    input  raster_pkg::rgb_t   v2_color,
    input  raster_pkg::fixed_t area_inv,
    // Pixel stream
    input  logic               pix_valid,
    output logic               pix_ready,
    input  raster_pkg::coord_t pix_x,
    input  raster_pkg::coord_t pix_y,
    // Shaded pixel stream
    output logic               out_valid,
    input  logic               out_ready,
    output raster_pkg::coord_t out_x,
    output raster_pkg::coord_t out_y,
    output logic               out_covered,
    output raster_pkg::rgb_t   out_color
);
    import raster_pkg::*;

    // Whole pipeline freezes when the sink is not ready
    logic stall;
    assign stall     = !out_ready;
    assign tri_ready = out_ready;
    assign pix_ready = out_ready;

    // Decode to execute
    logic   dec_valid;
    fixed_t f01, f12, f20, dec_area_inv;
    coord_t dec_v0_x, dec_v0_y, dec_v1_x, dec_v1_y, dec_v2_x, dec_v2_y;
    rgb_t   dec_v0_color, dec_v1_color, dec_v2_color;
    coord_t dec_pix_x, dec_pix_y;

    // Execute to result
    logic   exe_valid, exe_covered;
    fixed_t b0, b1, b2;
    rgb_t   exe_v0_color, exe_v1_color, exe_v2_color;
    coord_t exe_pix_x, exe_pix_y;

    edge_decode u_decode (
        .clk(clk), .rstn(rstn), .stall(stall),
        .tri_valid(tri_valid), .pix_valid(pix_valid),
        .v0_x(v0_x), .v0_y(v0_y), .v1_x(v1_x), .v1_y(v1_y), .v2_x(v2_x), .v2_y(v2_y),
        .v0_color(v0_color), .v1_color(v1_color), .v2_color(v2_color),
        .area_inv(area_inv), .pix_x(pix_x), .pix_y(pix_y),
        .dec_valid(dec_valid), .f01(f01), .f12(f12), .f20(f20),
        .dec_v0_x(dec_v0_x), .dec_v0_y(dec_v0_y), .dec_v1_x(dec_v1_x),
        .dec_v1_y(dec_v1_y), .dec_v2_x(dec_v2_x), .dec_v2_y(dec_v2_y),
        .dec_v0_color(dec_v0_color), .dec_v1_color(dec_v1_color),
        .dec_v2_color(dec_v2_color), .dec_area_inv(dec_area_inv),
        .dec_pix_x(dec_pix_x), .dec_pix_y(dec_pix_y)
    );

    coverage_execute #(
        .EDGE_TOLERANCE(EDGE_TOLERANCE)
    ) u_execute (
        .clk(clk), .rstn(rstn), .stall(stall), .dec_valid(dec_valid),
        .f01(f01), .f12(f12), .f20(f20), .area_inv(dec_area_inv),
        .v0_x(dec_v0_x), .v0_y(dec_v0_y), .v1_x(dec_v1_x), .v1_y(dec_v1_y),
        .v2_x(dec_v2_x), .v2_y(dec_v2_y),
        .v0_color(dec_v0_color), .v1_color(dec_v1_color), .v2_color(dec_v2_color),
        .pix_x(dec_pix_x), .pix_y(dec_pix_y),
        .exe_valid(exe_valid), .covered(exe_covered), .b0(b0), .b1(b1), .b2(b2),
        .exe_v0_color(exe_v0_color), .exe_v1_color(exe_v1_color),
        .exe_v2_color(exe_v2_color), .exe_pix_x(exe_pix_x), .exe_pix_y(exe_pix_y)
    );

    shade_result u_result (
        .clk(clk), .rstn(rstn), .stall(stall),
        .exe_valid(exe_valid), .covered(exe_covered), .b0(b0), .b1(b1), .b2(b2),
        .v0_color(exe_v0_color), .v1_color(exe_v1_color), .v2_color(exe_v2_color),
        .pix_x(exe_pix_x), .pix_y(exe_pix_y),
        .out_valid(out_valid), .out_x(out_x), .out_y(out_y),
        .out_covered(out_covered), .out_color(out_color)
    );

endmodule

//--- tests/interpolator_checker.sv
`timescale 1ns/1ps

module interpolator_checker (
    input  logic               clk,
    input  logic               rstn,
    input  logic               out_valid,
    input  logic               out_ready,
    input  logic               pix_ready,
    input  logic               tri_ready,
    input  raster_pkg::coord_t out_x,
    input  raster_pkg::coord_t out_y,
    input  logic               out_covered,
    input  raster_pkg::rgb_t   out_color
);

    // Running total of failed properties, read by the testbench top
    int assert_errors = 0;

    //////////////////////////////////////////////////
    // Stream protocol properties
    //////////////////////////////////////////////////

    // Output stream comes out of reset empty
    valid_low_after_reset: assert property (
        @(posedge clk) !rstn |=> !out_valid
    ) else begin
        $error("out_valid high in the cycle after reset");
        assert_errors++;
    end

    // Offered pixel must hold still until the sink takes it
    output_stable_on_stall: assert property (
        @(posedge clk) disable iff (!rstn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_x) && $stable(out_y)
                                       && $stable(out_covered) && $stable(out_color))
    ) else begin
        $error("output changed while out_ready was low");
        assert_errors++;
    end

    // Global stall, both input streams follow the sink
    ready_follows_sink: assert property (
        @(posedge clk) disable iff (!rstn)
        (pix_ready == out_ready) && (tri_ready == out_ready)
    ) else begin
        $error("input ready differs from out_ready");
        assert_errors++;
    end

endmodule

bind triangle_interpolator interpolator_checker u_checker (
    .clk(clk), .rstn(rstn), .out_valid(out_valid), .out_ready(out_ready),
    .pix_ready(pix_ready), .tri_ready(tri_ready), .out_x(out_x), .out_y(out_y),
    .out_covered(out_covered), .out_color(out_color)
);

//--- tests/pixel_monitor.sv
`timescale 1ns/1ps

module pixel_monitor #(
    parameter int NUM_ROWS = 1
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               pix_valid,
    input  logic               pix_ready,
    input  logic               out_valid,
    input  logic               out_ready,
    input  raster_pkg::coord_t out_x,
    input  raster_pkg::coord_t out_y,
    input  logic               out_covered,
    input  raster_pkg::rgb_t   out_color,
    output int                 tests_done,
    output int                 pass_count,
    output int                 error_count
);

    // Pixels accepted on the input side so far
    int pixels_in;

    // Compare one output transfer with row idx of the table
    task automatic check_output(input int idx);
        string diffs;
        diffs = "";
        if (out_x !== tb_triangle_interpolator.row_pix_x[idx]
            || out_y !== tb_triangle_interpolator.row_pix_y[idx]) begin
            diffs = {diffs, $sformatf(" pixel (%0d,%0d) expected (%0d,%0d)", out_x, out_y,
                     tb_triangle_interpolator.row_pix_x[idx],
                     tb_triangle_interpolator.row_pix_y[idx])};
        end
        if (out_covered !== tb_triangle_interpolator.exp_covered[idx]) begin
            diffs = {diffs, $sformatf(" covered %0b expected %0b", out_covered,
                     tb_triangle_interpolator.exp_covered[idx])};
        end
        if (out_color !== tb_triangle_interpolator.exp_color[idx]) begin
            diffs = {diffs, $sformatf(" color %06h expected %06h", out_color,
                     tb_triangle_interpolator.exp_color[idx])};
        end
        if (diffs == "") begin
            pass_count++;
            $display("Test %0d passed: pixel (%0d,%0d) covered %0b color %06h",
                     idx, out_x, out_y, out_covered, out_color);
        end else begin
            error_count++;
            $display("Fail at %0t: test %0d%s", $time, idx, diffs);
        end
    endtask

    //////////////////////////////////////////////////
    // Handshake tracking
    //////////////////////////////////////////////////

    // Output side first, then the input side of the same edge
    always @(posedge clk) begin
        if (rstn) begin
            if (out_valid && (tests_done >= pixels_in || tests_done >= NUM_ROWS)) begin
                error_count++;
                $display("Output valid at %0t with no pixel in flight", $time);
            end else if (out_valid && out_ready) begin
                check_output(tests_done);
                tests_done++;
            end
            if (pix_valid && pix_ready) begin
                pixels_in++;
            end
        end
    end

endmodule

//--- tests/tb_triangle_interpolator.sv
`timescale 1ns/1ps

module tb_triangle_interpolator;
    import raster_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_ROWS   = 13;
    localparam int PIPE_DEPTH = 4;

    // Triangles 0 and 1 share a shape with doubled area 256, triangle 2 has 1024
    localparam int     TRI_X [3][3] = '{'{0, 16, 0}, '{0, 16, 0}, '{10, 42, 10}};
    localparam int     TRI_Y [3][3] = '{'{0, 0, 16}, '{0, 0, 16}, '{10, 10, 42}};
    localparam rgb_t   TRI_C [3][3] = '{'{24'h4080C0, 24'h4080C0, 24'h4080C0},
                                        '{24'hFF0000, 24'h00FF00, 24'h0000FF},
                                        '{24'h800000, 24'h008000, 24'h000080}};
    // Reciprocal of doubled area with 16 fraction bits
    localparam fixed_t TRI_AREA_INV [3] = '{32'sd256, 32'sd256, 32'sd64};

    logic   clk, rstn;
    logic   tri_valid, tri_ready, pix_valid, pix_ready;
    coord_t v0_x, v0_y, v1_x, v1_y, v2_x, v2_y, pix_x, pix_y;
    rgb_t   v0_color, v1_color, v2_color;
    fixed_t area_inv;
    logic   out_valid, out_ready, out_covered;
    coord_t out_x, out_y;
    rgb_t   out_color;
    int     tests_done, pass_count, error_count;

    // Vector table, one row per pixel
    logic   row_new_tri [NUM_ROWS];
    coord_t row_vx [NUM_ROWS][3];
    coord_t row_vy [NUM_ROWS][3];
    rgb_t   row_vc [NUM_ROWS][3];
    fixed_t row_area_inv [NUM_ROWS];
    coord_t row_pix_x [NUM_ROWS];
    coord_t row_pix_y [NUM_ROWS];
    int     row_stall [NUM_ROWS];
    logic   exp_covered [NUM_ROWS];
    rgb_t   exp_color [NUM_ROWS];
    int     rows_loaded;
    bit     table_loaded;

    triangle_interpolator #(.EDGE_TOLERANCE(8)) dut (
        .clk(clk), .rstn(rstn), .tri_valid(tri_valid), .tri_ready(tri_ready),
        .v0_x(v0_x), .v0_y(v0_y), .v0_color(v0_color), .v1_x(v1_x), .v1_y(v1_y),
        .v1_color(v1_color), .v2_x(v2_x), .v2_y(v2_y), .v2_color(v2_color),
        .area_inv(area_inv), .pix_valid(pix_valid), .pix_ready(pix_ready),
        .pix_x(pix_x), .pix_y(pix_y), .out_valid(out_valid), .out_ready(out_ready),
        .out_x(out_x), .out_y(out_y), .out_covered(out_covered), .out_color(out_color)
    );

    pixel_monitor #(.NUM_ROWS(NUM_ROWS)) u_monitor (
        .clk(clk), .rstn(rstn), .pix_valid(pix_valid), .pix_ready(pix_ready),
        .out_valid(out_valid), .out_ready(out_ready), .out_x(out_x), .out_y(out_y),
        .out_covered(out_covered), .out_color(out_color), .tests_done(tests_done),
        .pass_count(pass_count), .error_count(error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Append one row, triangle fields copied from triangle t
    task automatic add_row(input int t, input logic new_tri, input int px, input int py,
                           input int stall, input logic cov, input rgb_t color);
        int r;
        r = rows_loaded;
        row_new_tri[r] = new_tri;
        for (int k = 0; k < 3; k++) begin
            row_vx[r][k] = coord_t'(TRI_X[t][k]);
            row_vy[r][k] = coord_t'(TRI_Y[t][k]);
            row_vc[r][k] = TRI_C[t][k];
        end
        row_area_inv[r] = TRI_AREA_INV[t];
        row_pix_x[r]    = coord_t'(px);
        row_pix_y[r]    = coord_t'(py);
        row_stall[r]    = stall;
        exp_covered[r]  = cov;
        exp_color[r]    = color;
        rows_loaded++;
    endtask

    //////////////////////////////////////////////////
    // Vector table
    //////////////////////////////////////////////////

    task automatic load_table();
        // tri, new, x, y, stall, covered, color
        // Flat color stays flat anywhere inside
        add_row(0, 1'b1,  4,  4, 0, 1'b1, 24'h4080C0);
        add_row(0, 1'b0,  5,  3, 0, 1'b1, 24'h4080C0);
        add_row(0, 1'b0,  2,  9, 2, 1'b1, 24'h4080C0);
        // Weights 1/2, 1/4, 1/4, fraction dropped
        add_row(1, 1'b1,  4,  4, 0, 1'b1, 24'h7F3F3F);
        // On a vertex, weight 1 there and 0 elsewhere
        add_row(1, 1'b0,  0,  0, 0, 1'b1, 24'hFF0000);
        add_row(1, 1'b0, 16,  0, 3, 1'b0, 24'h00FF00);
        add_row(1, 1'b0,  0, 16, 0, 1'b0, 24'h0000FF);
        // Outside, weights clipped to 0 and 1
        add_row(1, 1'b0, 20, 20, 1, 1'b0, 24'h00FFFF);
        // Top edge and left edge in, hypotenuse out
        add_row(1, 1'b0,  8,  0, 0, 1'b1, 24'h7F7F00);
        add_row(1, 1'b0,  0,  8, 0, 1'b1, 24'h7F007F);
        add_row(1, 1'b0,  8,  8, 2, 1'b0, 24'h007F7F);
        // Larger triangle away from the origin
        add_row(2, 1'b1, 18, 18, 0, 1'b1, 24'h402020);
        add_row(2, 1'b0, 10, 10, 4, 1'b1, 24'h800000);
        table_loaded = 1'b1;
    endtask

    // Offer row r, hold the sink off for its stall count, then transfer
    task automatic apply_row(input int r);
        tri_valid <= row_new_tri[r];
        v0_x      <= row_vx[r][0];
        v0_y      <= row_vy[r][0];
        v0_color  <= row_vc[r][0];
        v1_x      <= row_vx[r][1];
        v1_y      <= row_vy[r][1];
        v1_color  <= row_vc[r][1];
        v2_x      <= row_vx[r][2];
        v2_y      <= row_vy[r][2];
        v2_color  <= row_vc[r][2];
        area_inv  <= row_area_inv[r];
        pix_valid <= 1'b1;
        pix_x     <= row_pix_x[r];
        pix_y     <= row_pix_y[r];
        out_ready <= (row_stall[r] == 0);
        for (int n = 0; n < row_stall[r]; n++) begin
            @(posedge clk);
        end
        out_ready <= 1'b1;
        @(posedge clk);
    endtask

    initial begin
        rstn      <= 1'b0;
        tri_valid <= 1'b0;
        pix_valid <= 1'b0;
        out_ready <= 1'b1;
        v0_x      <= '0;
        v0_y      <= '0;
        v1_x      <= '0;
        v1_y      <= '0;
        v2_x      <= '0;
        v2_y      <= '0;
        v0_color  <= '0;
        v1_color  <= '0;
        v2_color  <= '0;
        area_inv  <= '0;
        pix_x     <= '0;
        pix_y     <= '0;
        load_table();
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        // Idle with the sink ready, nothing may come out yet
        repeat (6) @(posedge clk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        tri_valid <= 1'b0;
        pix_valid <= 1'b0;
        wait (tests_done == NUM_ROWS);
        // A few more cycles so a duplicated pixel would show
        repeat (2 * PIPE_DEPTH) @(posedge clk);
        $display("Tests done %0d of %0d, passed %0d, errors %0d, assertion failures %0d",
                 tests_done, NUM_ROWS, pass_count, error_count, dut.u_checker.assert_errors);
        if (pass_count == NUM_ROWS && error_count == 0
            && dut.u_checker.assert_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the table length and its longest stall
    initial begin
        int max_stall;
        int limit_ns;
        wait (table_loaded);
        max_stall = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_stall[r] > max_stall) begin
                max_stall = row_stall[r];
            end
        end
        limit_ns = (NUM_ROWS * (PIPE_DEPTH + max_stall + 2) + 8) * CLK_PERIOD * 2;
        #(limit_ns);
        $display("Timeout: only %0d of %0d outputs arrived, outputs are missing",
                 tests_done, NUM_ROWS);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- interpolator.f
common/raster_pkg.sv
interpolator/edge_decode.sv
interpolator/coverage_execute.sv
interpolator/shade_result.sv
logic/triangle_interpolator.sv
tests/interpolator_checker.sv
tests/pixel_monitor.sv
tests/tb_triangle_interpolator.sv

//--- Makefile
# Verilator build and run of the triangle interpolator testbench
# Every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_triangle_interpolator
FILELIST  ?= interpolator.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Simulation passed

.PHONY: sim clean

# Build, run into the log, then search the log for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
